// File: rtl/fabric_pkg.sv
package fabric_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  gpio_t;
    typedef logic [9:0]  tcm_index_t;

    localparam int tcm_words = 2 ** $bits(tcm_index_t);

    // access size of one bus transfer
    typedef enum logic [1:0] {
        acc_byte = 2'd0,
        acc_half = 2'd1,
        acc_word = 2'd2
    } acc_e;

    // instruction bus only reads
    typedef struct packed {
        addr_t addr;
        acc_e  acc;
    } ibus_cmd_t;

    // w_rb high means write, low means read
    // sized write data sits in the low bits of wdata
    typedef struct packed {
        addr_t addr;
        logic  w_rb;
        acc_e  acc;
        word_t wdata;
    } dbus_cmd_t;

    // owner of the shared tcm port
    typedef enum logic [1:0] {
        arb_idle = 2'd0,
        arb_ibus = 2'd1,
        arb_dbus = 2'd2
    } arb_state_e;

    // address map
    localparam addr_t tcm_base  = 32'h0001_0000;
    localparam addr_t tcm_mask  = 32'hFFFF_F000;
    localparam addr_t gpio_base = 32'h0002_0000;
    localparam addr_t gpio_mask = 32'hFFFF_FFF0;

    // gpio register offsets
    localparam logic [3:0] gpio_out_off = 4'h0;
    localparam logic [3:0] gpio_dir_off = 4'h4;
    localparam logic [3:0] gpio_in_off  = 4'h8;

endpackage

// File: rtl/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
    input  logic              clk,
    input  logic              ibus_req,
    input  fabric_pkg::addr_t ibus_addr,
    input  logic              dbus_req,
    input  fabric_pkg::addr_t dbus_addr,
    output logic              ibus_tcm_req,
    output logic              dbus_tcm_req,
    output logic              dbus_gpio_req,
    output logic              ibus_sel_tcm,
    output logic              dbus_sel_gpio,
    output logic              decode_fault
);
    import fabric_pkg::*;

    logic ibus_hit_tcm;
    logic dbus_hit_tcm;
    logic dbus_hit_gpio;
    logic ibus_unmapped;
    logic dbus_unmapped;

    // base/mask compare per target
    assign ibus_hit_tcm  = (ibus_addr & tcm_mask) == tcm_base;
    assign dbus_hit_tcm  = (dbus_addr & tcm_mask) == tcm_base;
    assign dbus_hit_gpio = (dbus_addr & gpio_mask) == gpio_base;

    // route the strobes
    assign ibus_tcm_req  = ibus_req & ibus_hit_tcm;
    assign dbus_tcm_req  = dbus_req & dbus_hit_tcm;
    assign dbus_gpio_req = dbus_req & dbus_hit_gpio;

    // gpio is not visible from the ibus
    assign ibus_unmapped = ibus_req & ~ibus_hit_tcm;
    assign dbus_unmapped = dbus_req & ~(dbus_hit_tcm | dbus_hit_gpio);
    assign decode_fault  = ibus_unmapped | dbus_unmapped;

    // response selects follow the last request of each bus
    always_ff @(posedge clk) begin
        if (ibus_req) begin
            ibus_sel_tcm <= ibus_hit_tcm;
        end
    end

    always_ff @(posedge clk) begin
        if (dbus_req) begin
            dbus_sel_gpio <= dbus_hit_gpio;
        end
    end

endmodule

// File: rtl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  ibus_req,
    input  fabric_pkg::ibus_cmd_t ibus_cmd,
    input  logic                  dbus_req,
    input  fabric_pkg::dbus_cmd_t dbus_cmd,
    output logic                  tcm_req,
    output fabric_pkg::dbus_cmd_t tcm_cmd,
    input  logic                  tcm_resp,
    output logic                  ibus_tcm_resp,
    output logic                  dbus_tcm_resp
);
    import fabric_pkg::*;

    ibus_cmd_t  ibus_cmd_q;
    dbus_cmd_t  dbus_cmd_q;
    ibus_cmd_t  ibus_cur;
    dbus_cmd_t  dbus_cur;
    logic       ibus_ongoing;
    logic       dbus_ongoing;
    arb_state_e state;
    arb_state_e next_state;

    // capture commands, transparent in the request cycle
    always_ff @(posedge clk) begin
        if (ibus_req) begin
            ibus_cmd_q <= ibus_cmd;
        end
        if (dbus_req) begin
            dbus_cmd_q <= dbus_cmd;
        end
    end

    assign ibus_cur = ibus_req ? ibus_cmd : ibus_cmd_q;
    assign dbus_cur = dbus_req ? dbus_cmd : dbus_cmd_q;

    // set on request, cleared by its own response
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ibus_ongoing <= 1'b0;
            dbus_ongoing <= 1'b0;
        end else begin
            if (ibus_req | ibus_tcm_resp) begin
                ibus_ongoing <= ibus_req;
            end
            if (dbus_req | dbus_tcm_resp) begin
                dbus_ongoing <= dbus_req;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= arb_idle;
        end else begin
            state <= next_state;
        end
    end

    // hand the port to the other bus after each completion
    always_comb begin
        next_state = state;
        case (state)
            arb_ibus: begin
                if (tcm_resp) begin
                    if (dbus_req | dbus_ongoing) begin
                        next_state = arb_dbus;
                    end else if (ibus_req) begin
                        next_state = arb_ibus;
                    end else begin
                        next_state = arb_idle;
                    end
                end
            end
            arb_dbus: begin
                if (tcm_resp) begin
                    if (ibus_req | ibus_ongoing) begin
                        next_state = arb_ibus;
                    end else if (dbus_req) begin
                        next_state = arb_dbus;
                    end else begin
                        next_state = arb_idle;
                    end
                end
            end
            default: begin
                if (dbus_req) begin
                    next_state = arb_dbus;
                end else if (ibus_req) begin
                    next_state = arb_ibus;
                end else begin
                    next_state = arb_idle;
                end
            end
        endcase
    end

    // new access starts from idle or right on a completion
    always_comb begin
        case (state)
            arb_ibus: tcm_req = tcm_resp & (dbus_req | dbus_ongoing | ibus_req);
            arb_dbus: tcm_req = tcm_resp & (ibus_req | ibus_ongoing | dbus_req);
            default:  tcm_req = ibus_req | dbus_req;
        endcase
    end

    // ibus command widened to a read
    always_comb begin
        case (next_state)
            arb_ibus: tcm_cmd = '{addr: ibus_cur.addr, w_rb: 1'b0, acc: ibus_cur.acc, wdata: '0};
            arb_dbus: tcm_cmd = dbus_cur;
            default:  tcm_cmd = '0;
        endcase
    end

    assign ibus_tcm_resp = tcm_resp & (state == arb_ibus);
    assign dbus_tcm_resp = tcm_resp & (state == arb_dbus);

endmodule

// File: rtl/tcm_target.sv
`timescale 1ns/1ps

module tcm_target (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  tcm_req,
    input  fabric_pkg::dbus_cmd_t tcm_cmd,
    output logic                  tcm_resp,
    output fabric_pkg::word_t     tcm_rdata,
    output logic                  tcm_fault
);
    import fabric_pkg::*;

    word_t      mem [tcm_words];
    tcm_index_t index;
    logic [3:0] byte_en;
    word_t      lane_data;
    logic       misaligned;

    assign index = tcm_cmd.addr[11:2];

    // lane enables from size and low address bits
    always_comb begin
        byte_en    = 4'b0000;
        lane_data  = tcm_cmd.wdata;
        misaligned = 1'b0;
        case (tcm_cmd.acc)
            acc_byte: begin
                byte_en   = 4'b0001 << tcm_cmd.addr[1:0];
                lane_data = {4{tcm_cmd.wdata[7:0]}};
            end
            acc_half: begin
                byte_en    = 4'b0011 << {tcm_cmd.addr[1], 1'b0};
                lane_data  = {2{tcm_cmd.wdata[15:0]}};
                misaligned = tcm_cmd.addr[0];
            end
            acc_word: begin
                byte_en    = 4'b1111;
                misaligned = |tcm_cmd.addr[1:0];
            end
            // unused size code
            default: misaligned = 1'b1;
        endcase
    end

    assign tcm_fault = tcm_req & misaligned;

    always_ff @(posedge clk) begin
        if (tcm_req & ~misaligned & tcm_cmd.w_rb) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem[index][8*i +: 8] <= lane_data[8*i +: 8];
                end
            end
        end
    end

    // whole aligned word, reads and writes alike
    always_ff @(posedge clk) begin
        if (tcm_req) begin
            tcm_rdata <= mem[index];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tcm_resp <= 1'b0;
        end else begin
            tcm_resp <= tcm_req & ~misaligned;
        end
    end

endmodule

// File: rtl/gpio_target.sv
`timescale 1ns/1ps

module gpio_target (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  gpio_req,
    input  fabric_pkg::dbus_cmd_t gpio_cmd,
    output logic                  gpio_resp,
    output fabric_pkg::word_t     gpio_rdata,
    input  fabric_pkg::gpio_t     gpio_i,
    output fabric_pkg::gpio_t     gpio_o,
    output fabric_pkg::gpio_t     gpio_dir
);
    import fabric_pkg::*;

    gpio_t      gpio_in_q;
    logic [3:0] offset;

    assign offset = gpio_cmd.addr[3:0];

    // input sampling
    always_ff @(posedge clk) begin
        gpio_in_q <= gpio_i;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            gpio_o    <= '0;
            gpio_dir  <= '0;
            gpio_resp <= 1'b0;
        end else begin
            gpio_resp <= gpio_req;
            if (gpio_req & gpio_cmd.w_rb) begin
                if (offset == gpio_out_off) begin
                    gpio_o <= gpio_cmd.wdata[7:0];
                end
                if (offset == gpio_dir_off) begin
                    gpio_dir <= gpio_cmd.wdata[7:0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (gpio_req) begin
            case (offset)
                gpio_out_off: gpio_rdata <= {24'b0, gpio_o};
                gpio_dir_off: gpio_rdata <= {24'b0, gpio_dir};
                gpio_in_off:  gpio_rdata <= {24'b0, gpio_in_q};
                default:      gpio_rdata <= '0;
            endcase
        end
    end

endmodule

// File: rtl/resp_merge.sv
`timescale 1ns/1ps

module resp_merge (
    input  logic              clk,
    input  logic              rstn,
    input  logic              ibus_sel_tcm,
    input  logic              dbus_sel_gpio,
    input  logic              ibus_tcm_resp,
    input  logic              dbus_tcm_resp,
    input  fabric_pkg::word_t tcm_rdata,
    input  logic              gpio_resp,
    input  fabric_pkg::word_t gpio_rdata,
    input  logic              decode_fault,
    input  logic              tcm_fault,
    output logic              ibus_resp,
    output fabric_pkg::word_t ibus_rdata,
    output logic              dbus_resp,
    output fabric_pkg::word_t dbus_rdata,
    output logic              fault
);
    import fabric_pkg::*;

    // sticky until reset
    always_ff @(posedge clk) begin
        if (!rstn) begin
            fault <= 1'b0;
        end else if (decode_fault | tcm_fault) begin
            fault <= 1'b1;
        end
    end

    // ibus reaches only the tcm
    assign ibus_rdata = ibus_sel_tcm ? tcm_rdata : '0;
    assign dbus_rdata = dbus_sel_gpio ? gpio_rdata : tcm_rdata;

    // nothing gets out once faulted
    assign ibus_resp = ibus_tcm_resp & ~fault;
    assign dbus_resp = (dbus_tcm_resp | gpio_resp) & ~fault;

endmodule

// File: rtl/femto_fabric.sv
`timescale 1ns/1ps

module femto_fabric (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  ibus_req,
    input  fabric_pkg::ibus_cmd_t ibus_cmd,
    output logic                  ibus_resp,
    output fabric_pkg::word_t     ibus_rdata,
    input  logic                  dbus_req,
    input  fabric_pkg::dbus_cmd_t dbus_cmd,
    output logic                  dbus_resp,
    output fabric_pkg::word_t     dbus_rdata,
    input  fabric_pkg::gpio_t     gpio_i,
    output fabric_pkg::gpio_t     gpio_o,
    output fabric_pkg::gpio_t     gpio_dir,
    output logic                  fault
);
    import fabric_pkg::*;

    logic      ibus_tcm_req;
    logic      dbus_tcm_req;
    logic      dbus_gpio_req;
    logic      ibus_sel_tcm;
    logic      dbus_sel_gpio;
    logic      decode_fault;
    logic      tcm_req;
    dbus_cmd_t tcm_cmd;
    logic      tcm_resp;
    word_t     tcm_rdata;
    logic      tcm_fault;
    logic      ibus_tcm_resp;
    logic      dbus_tcm_resp;
    logic      gpio_resp;
    word_t     gpio_rdata;

    bus_decoder i_bus_decoder (
        .clk           (clk),
        .ibus_req      (ibus_req),
        .ibus_addr     (ibus_cmd.addr),
        .dbus_req      (dbus_req),
        .dbus_addr     (dbus_cmd.addr),
        .ibus_tcm_req  (ibus_tcm_req),
        .dbus_tcm_req  (dbus_tcm_req),
        .dbus_gpio_req (dbus_gpio_req),
        .ibus_sel_tcm  (ibus_sel_tcm),
        .dbus_sel_gpio (dbus_sel_gpio),
        .decode_fault  (decode_fault)
    );

    bus_arbiter i_bus_arbiter (
        .clk           (clk),
        .rstn          (rstn),
        .ibus_req      (ibus_tcm_req),
        .ibus_cmd      (ibus_cmd),
        .dbus_req      (dbus_tcm_req),
        .dbus_cmd      (dbus_cmd),
        .tcm_req       (tcm_req),
        .tcm_cmd       (tcm_cmd),
        .tcm_resp      (tcm_resp),
        .ibus_tcm_resp (ibus_tcm_resp),
        .dbus_tcm_resp (dbus_tcm_resp)
    );

    tcm_target i_tcm_target (
        .clk       (clk),
        .rstn      (rstn),
        .tcm_req   (tcm_req),
        .tcm_cmd   (tcm_cmd),
        .tcm_resp  (tcm_resp),
        .tcm_rdata (tcm_rdata),
        .tcm_fault (tcm_fault)
    );

    gpio_target i_gpio_target (
        .clk        (clk),
        .rstn       (rstn),
        .gpio_req   (dbus_gpio_req),
        .gpio_cmd   (dbus_cmd),
        .gpio_resp  (gpio_resp),
        .gpio_rdata (gpio_rdata),
        .gpio_i     (gpio_i),
        .gpio_o     (gpio_o),
        .gpio_dir   (gpio_dir)
    );

    resp_merge i_resp_merge (
        .clk           (clk),
        .rstn          (rstn),
        .ibus_sel_tcm  (ibus_sel_tcm),
        .dbus_sel_gpio (dbus_sel_gpio),
        .ibus_tcm_resp (ibus_tcm_resp),
        .dbus_tcm_resp (dbus_tcm_resp),
        .tcm_rdata     (tcm_rdata),
        .gpio_resp     (gpio_resp),
        .gpio_rdata    (gpio_rdata),
        .decode_fault  (decode_fault),
        .tcm_fault     (tcm_fault),
        .ibus_resp     (ibus_resp),
        .ibus_rdata    (ibus_rdata),
        .dbus_resp     (dbus_resp),
        .dbus_rdata    (dbus_rdata),
        .fault         (fault)
    );

endmodule

// File: verif/fabric_checker.sv
`timescale 1ns/1ps

module fabric_checker (
    input logic clk,
    input logic rstn,
    input logic ibus_req,
    input logic ibus_resp,
    input logic dbus_req,
    input logic dbus_resp,
    input logic fault
);

    int unsigned assert_fails = 0;
    logic        ibus_pend;
    logic        dbus_pend;

    // request in flight per bus
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ibus_pend <= 1'b0;
            dbus_pend <= 1'b0;
        end else begin
            if (ibus_req) begin
                ibus_pend <= 1'b1;
            end else if (ibus_resp) begin
                ibus_pend <= 1'b0;
            end
            if (dbus_req) begin
                dbus_pend <= 1'b1;
            end else if (dbus_resp) begin
                dbus_pend <= 1'b0;
            end
        end
    end

    ibus_resp_pending: assert property (@(posedge clk) disable iff (!rstn)
        ibus_resp |-> ibus_pend)
        else begin
            $error("ibus response without an outstanding request");
            assert_fails++;
        end

    dbus_resp_pending: assert property (@(posedge clk) disable iff (!rstn)
        dbus_resp |-> dbus_pend)
        else begin
            $error("dbus response without an outstanding request");
            assert_fails++;
        end

    // only a reset clears the fault
    fault_sticky: assert property (@(posedge clk)
        rstn && $past(rstn) |-> !$fell(fault))
        else begin
            $error("fault fell while out of reset");
            assert_fails++;
        end

    fault_blocks_resp: assert property (@(posedge clk) disable iff (!rstn)
        fault |-> !ibus_resp && !dbus_resp)
        else begin
            $error("response seen while fault is set");
            assert_fails++;
        end

endmodule

bind femto_fabric fabric_checker i_fabric_checker (
    .clk       (clk),
    .rstn      (rstn),
    .ibus_req  (ibus_req),
    .ibus_resp (ibus_resp),
    .dbus_req  (dbus_req),
    .dbus_resp (dbus_resp),
    .fault     (fault)
);

// File: verif/femto_fabric_tb.sv
`timescale 1ns/1ps

module femto_fabric_tb;
    import fabric_pkg::*;

    localparam int resp_timeout = 20;
    localparam int num_words    = 16;

    logic      clk;
    logic      rstn;
    logic      ibus_req;
    ibus_cmd_t ibus_cmd;
    logic      ibus_resp;
    word_t     ibus_rdata;
    logic      dbus_req;
    dbus_cmd_t dbus_cmd;
    logic      dbus_resp;
    word_t     dbus_rdata;
    gpio_t     gpio_i;
    gpio_t     gpio_o;
    gpio_t     gpio_dir;
    logic      fault;

    // reference model of the first tcm words and the gpio registers
    word_t ref_mem [num_words];
    gpio_t ref_gpio_o;
    gpio_t ref_gpio_dir;

    // expected responses in issue order
    word_t ibus_exp_q [$];
    word_t dbus_exp_q [$];
    bit    dbus_chk_q [$];

    femto_fabric i_femto_fabric (.*);

    always #5 clk = ~clk;

    function automatic word_t sized_write(word_t old, addr_t addr, acc_e acc, word_t wdata);
        word_t result;
        result = old;
        case (acc)
            acc_byte: result[8*addr[1:0] +: 8] = wdata[7:0];
            acc_half: result[16*addr[1] +: 16] = wdata[15:0];
            default:  result = wdata;
        endcase
        return result;
    endfunction

    function automatic addr_t tcm_addr(int i);
        return tcm_base + addr_t'(4 * i);
    endfunction

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_word(string what, word_t got, word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic compare_gpio(string what, gpio_t got, gpio_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic compare_bit(string what, logic got, bit exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t %s: got %b, expected %b", $time, what, got, exp));
        end
    endtask

    // every response is matched against the head of its queue
    always @(negedge clk) begin
        if (i_femto_fabric.i_fabric_checker.assert_fails != 0) begin
            abort_run("an assertion in fabric_checker failed");
        end
        if (dbus_resp === 1'b1) begin
            if (dbus_exp_q.size() == 0) begin
                abort_run("dbus response with no request outstanding");
            end else if (dbus_chk_q.pop_front()) begin
                compare_word("dbus read data", dbus_rdata, dbus_exp_q.pop_front());
            end else begin
                void'(dbus_exp_q.pop_front());
            end
        end
        if (ibus_resp === 1'b1) begin
            if (ibus_exp_q.size() == 0) begin
                abort_run("ibus response with no request outstanding");
            end else begin
                compare_word("ibus read data", ibus_rdata, ibus_exp_q.pop_front());
            end
        end
    end

    task automatic apply_reset();
        rstn = 1'b0;
        repeat (10) @(negedge clk);
        rstn         = 1'b1;
        ref_gpio_o   = '0;
        ref_gpio_dir = '0;
        compare_bit("fault after reset", fault, 1'b0);
        compare_gpio("gpio_o after reset", gpio_o, ref_gpio_o);
        compare_gpio("gpio_dir after reset", gpio_dir, ref_gpio_dir);
    endtask

    // returns one cycle after the response
    task automatic wait_resp(bit on_ibus);
        int cycles;
        cycles = 0;
        @(negedge clk);
        ibus_req = 1'b0;
        dbus_req = 1'b0;
        while ((on_ibus ? ibus_resp : dbus_resp) !== 1'b1) begin
            if (cycles == resp_timeout) begin
                abort_run($sformatf("no %s response within %0d cycles",
                                    on_ibus ? "ibus" : "dbus", resp_timeout));
            end
            cycles++;
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic dbus_write(addr_t addr, acc_e acc, word_t wdata);
        dbus_exp_q.push_back('0);
        dbus_chk_q.push_back(1'b0);
        dbus_req = 1'b1;
        dbus_cmd = '{addr: addr, w_rb: 1'b1, acc: acc, wdata: wdata};
        wait_resp(1'b0);
    endtask

    task automatic dbus_read(addr_t addr, word_t exp);
        dbus_exp_q.push_back(exp);
        dbus_chk_q.push_back(1'b1);
        dbus_req = 1'b1;
        dbus_cmd = '{addr: addr, w_rb: 1'b0, acc: acc_word, wdata: '0};
        wait_resp(1'b0);
    endtask

    task automatic ibus_read(addr_t addr, word_t exp);
        ibus_exp_q.push_back(exp);
        ibus_req = 1'b1;
        ibus_cmd = '{addr: addr, acc: acc_word};
        wait_resp(1'b1);
    endtask

    // both buses hit the tcm in the same cycle
    task automatic dual_read(addr_t daddr, word_t dexp, addr_t iaddr, word_t iexp);
        int cycles;
        int dbus_at;
        int ibus_at;
        cycles  = 0;
        dbus_at = -1;
        ibus_at = -1;
        dbus_exp_q.push_back(dexp);
        dbus_chk_q.push_back(1'b1);
        ibus_exp_q.push_back(iexp);
        dbus_req = 1'b1;
        dbus_cmd = '{addr: daddr, w_rb: 1'b0, acc: acc_word, wdata: '0};
        ibus_req = 1'b1;
        ibus_cmd = '{addr: iaddr, acc: acc_word};
        @(negedge clk);
        dbus_req = 1'b0;
        ibus_req = 1'b0;
        while (dbus_at < 0 || ibus_at < 0) begin
            if (dbus_resp === 1'b1) begin
                dbus_at = cycles;
            end
            if (ibus_resp === 1'b1) begin
                ibus_at = cycles;
            end
            if (cycles == resp_timeout) begin
                abort_run("simultaneous tcm reads did not both get a response");
            end
            cycles++;
            @(negedge clk);
        end
        if (dbus_at >= ibus_at) begin
            abort_run("ibus answered before dbus on simultaneous tcm requests");
        end
    endtask

    // any response to a faulting or blocked access trips the compare process
    task automatic dbus_no_resp(addr_t addr, logic w_rb, word_t wdata);
        dbus_req = 1'b1;
        dbus_cmd = '{addr: addr, w_rb: w_rb, acc: acc_word, wdata: wdata};
        @(negedge clk);
        dbus_req = 1'b0;
        compare_bit("fault", fault, 1'b1);
        repeat (resp_timeout) @(negedge clk);
    endtask

    initial begin
        int    idx;
        int    offset;
        acc_e  acc;
        word_t wdata;
        clk      = 1'b0;
        rstn     = 1'b0;
        ibus_req = 1'b0;
        ibus_cmd = '0;
        dbus_req = 1'b0;
        dbus_cmd = '0;
        gpio_i   = '0;
        void'($urandom(23982));
        apply_reset();

        for (int i = 0; i < num_words; i++) begin
            ref_mem[i] = $urandom();
            dbus_write(tcm_addr(i), acc_word, ref_mem[i]);
        end
        for (int n = 0; n < 32; n++) begin
            idx   = $urandom_range(num_words - 1);
            acc   = acc_e'($urandom_range(2));
            wdata = $urandom();
            case (acc)
                acc_byte: offset = $urandom_range(3);
                acc_half: offset = 2 * $urandom_range(1);
                default:  offset = 0;
            endcase
            dbus_write(tcm_addr(idx) + addr_t'(offset), acc, wdata);
            ref_mem[idx] = sized_write(ref_mem[idx], tcm_addr(idx) + addr_t'(offset), acc, wdata);
        end
        for (int i = 0; i < num_words; i++) begin
            dbus_read(tcm_addr(i), ref_mem[i]);
        end
        for (int i = 0; i < num_words; i++) begin
            ibus_read(tcm_addr(i), ref_mem[i]);
        end
        dual_read(tcm_addr(3), ref_mem[3], tcm_addr(9), ref_mem[9]);

        wdata = $urandom();
        dbus_write(gpio_base + gpio_out_off, acc_word, wdata);
        ref_gpio_o = wdata[7:0];
        compare_gpio("gpio_o", gpio_o, ref_gpio_o);
        wdata = $urandom();
        dbus_write(gpio_base + gpio_dir_off, acc_word, wdata);
        ref_gpio_dir = wdata[7:0];
        compare_gpio("gpio_dir", gpio_dir, ref_gpio_dir);
        // input register is read only
        dbus_write(gpio_base + gpio_in_off, acc_word, $urandom());
        compare_gpio("gpio_o", gpio_o, ref_gpio_o);
        compare_gpio("gpio_dir", gpio_dir, ref_gpio_dir);
        gpio_i = gpio_t'($urandom());
        repeat (2) @(negedge clk);
        dbus_read(gpio_base + gpio_in_off, {24'b0, gpio_i});
        dbus_read(gpio_base + gpio_out_off, {24'b0, ref_gpio_o});
        dbus_read(gpio_base + gpio_dir_off, {24'b0, ref_gpio_dir});

        // unmapped access and a blocked tcm read after it
        dbus_no_resp(32'h0003_0000, 1'b0, '0);
        dbus_no_resp(tcm_addr(0), 1'b0, '0);
        apply_reset();
        dbus_read(tcm_addr(0), ref_mem[0]);

        // misaligned word write leaves memory untouched
        dbus_no_resp(tcm_addr(7) + 32'd2, 1'b1, $urandom());
        apply_reset();
        dbus_read(tcm_addr(7), ref_mem[7]);
        ibus_read(tcm_addr(7), ref_mem[7]);

        if (dbus_exp_q.size() != 0 || ibus_exp_q.size() != 0) begin
            abort_run("responses still outstanding at the end of the run");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// File: filelist.f
rtl/fabric_pkg.sv
rtl/bus_decoder.sv
rtl/bus_arbiter.sv
rtl/tcm_target.sv
rtl/gpio_target.sv
rtl/resp_merge.sv
rtl/femto_fabric.sv
verif/fabric_checker.sv
verif/femto_fabric_tb.sv
